/* sim/clint_stimulus.txt */
# op    addr     wr_data  expect   gap   (op: read write rdwr wfi ext idle, hex fields)
# expect: read data, t = timer model, - = ignore; other ops {cpu_halt,sw_irq,timer_irq}
read   0200BFF8 00000000 t        0
read   0200BFFC 00000000 0        1
read   02004000 00000000 ffffffff 0
read   02004004 00000000 ffffffff 0
read   02000000 00000000 0        0
idle   00000000 00000000 0        2
write  0200BFF8 00001000 0        3
read   0200BFF8 00000000 t        5
read   0200BFFC 00000000 t        0
read   0200BFF8 00000000 t        0
write  02004004 00000000 0        0
write  02004000 00001020 0        0
read   02004000 00000000 00001020 0
idle   00000000 00000000 0        0
idle   00000000 00000000 0        5
idle   00000000 00000000 0        0
idle   00000000 00000000 1        0
write  02004000 ffffffff 0        0
write  02004004 ffffffff 0        0
write  02000000 00000001 2        0
read   02000000 00000000 1        0
wfi    00000000 00000000 2        1
write  02000000 00000000 0        0
wfi    00000000 00000000 4        3
idle   00000000 00000000 4        0
ext    00000000 00000000 0        0
read   02000008 00000000 0        0
rdwr   0200BFF8 00000000 0        0
write  02004008 12345678 0        0
read   0200BFF8 00000000 t        0
rdwr   02000000 00000001 0        0
read   02000000 00000000 0        0
read   02004000 00000000 ffffffff 0
read   02004004 00000000 ffffffff 0
write  0200BFFC 00000001 0        2
read   0200BFFC 00000000 t        0
read   0200BFF8 00000000 t        0
idle   00000000 00000000 0        1

/* all.f */
logic/clint_pkg.sv
logic/mmr_wr_if.sv
logic/clint_ctrl.sv
logic/mtime_counter.sv
logic/timer_compare.sv
logic/clint_top.sv
sim/clint_properties.sv
sim/clint_tb.sv

/* sim/clint_tb.sv */
`timescale 1ns/1ps

module clint_tb
   import clint_pkg::*;
();

   logic               clk_in;
   logic               rst;
   logic               io_req;
   logic  [ADDR_W-1:0] io_addr;
   logic               io_rd;
   logic               io_wr;
   logic    [XLEN-1:0] io_wr_data;
   logic               ext_irq;
   logic               wfi;
   logic               io_ack;
   logic               io_ack_fault;
   logic    [XLEN-1:0] io_ack_data;
   logic               timer_irq;
   logic               sw_irq;
   logic               cpu_halt;

   // Stimulus table, one entry per file line
   string              op_q[$];
   logic  [ADDR_W-1:0] addr_q[$];
   logic    [XLEN-1:0] data_q[$];
   string              exp_q[$];
   int                 gap_q[$];

   int                 edges = 0;                     // Rising edges seen so far
   logic  [TIME_W-1:0] base_val;                      // mtime model, value after base_edge
   int                 base_edge;
   logic               stim_loaded = 1'b0;
   longint             watchdog_ns;

   clint_top UUT
   (
      .clk_in(clk_in), .rst(rst),
      .io_req(io_req), .io_addr(io_addr), .io_rd(io_rd), .io_wr(io_wr),
      .io_wr_data(io_wr_data), .ext_irq(ext_irq), .wfi(wfi),
      .io_ack(io_ack), .io_ack_fault(io_ack_fault), .io_ack_data(io_ack_data),
      .timer_irq(timer_irq), .sw_irq(sw_irq), .cpu_halt(cpu_halt)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;                   // 100 ns period
   end

   // -------------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp));
   endtask

   task automatic tick();
      @(posedge clk_in);
      edges = edges + 1;
   endtask

   // mtime as held just after edge e
   function automatic logic [63:0] mtime_at(input int e);
      mtime_at = base_val + (e - base_edge);
   endfunction

   function automatic logic is_mapped(input logic [ADDR_W-1:0] a);
      is_mapped = (a == MSIP_ADDR) || (a == MTIMECMP_LO_ADDR) || (a == MTIMECMP_HI_ADDR) ||
                  (a == MTIME_LO_ADDR) || (a == MTIME_HI_ADDR);
   endfunction

   task automatic load_stimulus();
      int                 fd;
      int                 fields;
      int                 total;                      // Cycles for the whole run
      string              line;
      string              op_s;
      string              exp_s;
      logic  [ADDR_W-1:0] a;
      logic    [XLEN-1:0] d;
      int                 g;
      fd    = $fopen("sim/clint_stimulus.txt", "r");
      total = 10 + 20;                                // Reset plus margin
      if (fd == 0)
         abort_run("cannot open the stimulus file sim/clint_stimulus.txt");
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#")  // Skip column notes
            begin
               fields = $sscanf(line, "%s %h %h %s %d", op_s, a, d, exp_s, g);
               if (fields == 5)
               begin
                  op_q.push_back(op_s);
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  exp_q.push_back(exp_s);
                  gap_q.push_back(g);
                  total = total + 2 + g;              // Drive edge, request edge, gap
               end
               else if (fields > 0)
                  abort_run($sformatf("malformed stimulus line: %s", line));
            end
         end
         $fclose(fd);
         watchdog_ns = total * 100;
         stim_loaded = 1'b1;
      end
   endtask

   // -------------------------------------------------------------------------
   // Watchdog and assertion monitor
   // -------------------------------------------------------------------------
   initial
   begin
      wait (stim_loaded);
      #(watchdog_ns);
      abort_run($sformatf("timeout: the run did not finish within %0d ns", watchdog_ns));
   end

   initial
   begin
      wait (UUT.props.assert_fails != 0);
      abort_run("a concurrent assertion on the DUT ports failed");
   end

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial
   begin
      string        op;
      string        exp_s;
      logic  [31:0] exp32;
      logic  [63:0] prev;
      logic         is_req;
      logic         fault;
      io_req     <= 1'b0;                             // All inputs idle, reset asserted
      io_addr    <= '0;
      io_rd      <= 1'b0;
      io_wr      <= 1'b0;
      io_wr_data <= '0;
      ext_irq    <= 1'b0;
      wfi        <= 1'b0;
      rst        <= 1'b1;
      load_stimulus();

      repeat (10) tick();
      rst       <= 1'b0;
      base_edge = edges;                              // Last reset edge leaves mtime at 0
      base_val  = '0;

      for (int i = 0; i < op_q.size(); i++)
      begin
         op     = op_q[i];
         exp_s  = exp_q[i];
         is_req = (op == "read") || (op == "write") || (op == "rdwr");
         fault  = (op == "rdwr") || !is_mapped(addr_q[i]);

         tick();                                      // Drive edge
         io_req     <= is_req;
         io_addr    <= addr_q[i];
         io_wr_data <= data_q[i];
         io_rd      <= (op == "read") || (op == "rdwr");
         io_wr      <= (op == "write") || (op == "rdwr");
         wfi        <= (op == "wfi");
         ext_irq    <= (op == "ext");

         tick();                                      // Request edge, strobes end here
         io_req  <= 1'b0;
         io_rd   <= 1'b0;
         io_wr   <= 1'b0;
         wfi     <= 1'b0;
         ext_irq <= 1'b0;
         prev    = mtime_at(edges - 1);               // Value before the request edge

         if (op == "write" && !fault && addr_q[i] == MTIME_LO_ADDR)
         begin
            base_val  = {prev[63:32], data_q[i]};     // Upper word holds
            base_edge = edges;
         end
         else if (op == "write" && !fault && addr_q[i] == MTIME_HI_ADDR)
         begin
            base_val  = {data_q[i], prev[31:0]};      // Lower word holds
            base_edge = edges;
         end

         @(negedge clk_in);
         if (is_req && io_ack !== 1'b1)
            abort_run($sformatf("no io_ack one cycle after the request of step %0d", i + 1));
         else if (!is_req && io_ack !== 1'b0)
            abort_run($sformatf("io_ack without a request at step %0d", i + 1));
         else if (is_req)
         begin
            check_value("io_ack_fault", io_ack_fault, fault);
            if (op != "write")
            begin
               if (fault)
                  check_value("io_ack_data", io_ack_data, 0);   // Faults read zero
               else if (exp_s == "t")
                  check_value("io_ack_data", io_ack_data,
                              (addr_q[i] == MTIME_HI_ADDR) ? prev[63:32] : prev[31:0]);
               else if (exp_s != "-")
               begin
                  exp32 = exp_s.atohex();
                  check_value("io_ack_data", io_ack_data, exp32);
               end
            end
         end

         // Status after the request edge, {cpu_halt, sw_irq, timer_irq}
         if (op != "read" && op != "rdwr" && exp_s != "-")
         begin
            exp32 = exp_s.atohex();
            check_value("cpu_halt", cpu_halt, exp32[2]);
            check_value("sw_irq", sw_irq, exp32[1]);
            check_value("timer_irq", timer_irq, exp32[0]);
         end

         for (int k = 0; k < gap_q[i]; k++)
         begin
            tick();
            @(negedge clk_in);
            if (io_ack !== 1'b0)
               abort_run($sformatf("unexpected io_ack in the idle cycles after step %0d",
                                   i + 1));
         end
      end

      tick();                                         // Let the last assertions sample
      @(negedge clk_in);                              // Past that edge, its checks are done
      if (UUT.props.assert_fails == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
         abort_run("concurrent assertions failed during the run");
   end

endmodule

/* sim/clint_properties.sv */
`timescale 1ns/1ps

// Port-level rules of the interrupt block
module clint_properties
(
   input  logic clk_in,
   input  logic rst,
   input  logic io_req,
   input  logic io_ack,
   input  logic io_ack_fault,
   input  logic ext_irq,
   input  logic timer_irq,
   input  logic sw_irq,
   input  logic cpu_halt
);

   int assert_fails = 0;                              // Watched by the testbench

   // Ack exactly one cycle after each request
   a_ack_after_req: assert property (@(posedge clk_in) disable iff (rst) io_req |=> io_ack)
   else
   begin
      $error("io_ack missing one cycle after io_req");
      assert_fails = assert_fails + 1;
   end

   // No ack without a request the cycle before
   a_no_stray_ack: assert property (@(posedge clk_in) disable iff (rst) !io_req |=> !io_ack)
   else
   begin
      $error("io_ack without io_req one cycle earlier");
      assert_fails = assert_fails + 1;
   end

   a_fault_in_ack: assert property (@(posedge clk_in) io_ack_fault |-> io_ack)
   else
   begin
      $error("io_ack_fault outside an ack cycle");
      assert_fails = assert_fails + 1;
   end

   // Any pending interrupt wakes the CPU at the next edge
   a_wake: assert property (@(posedge clk_in) disable iff (rst)
                            (ext_irq || timer_irq || sw_irq) |=> !cpu_halt)
   else
   begin
      $error("cpu_halt still set after an interrupt");
      assert_fails = assert_fails + 1;
   end

   // -------------------------------------------------------------------------
   // Reset state of the control outputs
   // -------------------------------------------------------------------------
   a_reset_state: assert property (@(posedge clk_in)
                                   rst |=> !(io_ack || io_ack_fault || cpu_halt ||
                                             timer_irq || sw_irq))
   else
   begin
      $error("control outputs not cleared by reset");
      assert_fails = assert_fails + 1;
   end

endmodule

bind clint_top clint_properties props
(
   .clk_in(clk_in), .rst(rst), .io_req(io_req), .io_ack(io_ack),
   .io_ack_fault(io_ack_fault), .ext_irq(ext_irq), .timer_irq(timer_irq),
   .sw_irq(sw_irq), .cpu_halt(cpu_halt)
);

/* logic/clint_top.sv */
`timescale 1ns/1ps

module clint_top
   import clint_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst,

   // I/O request port
   input  logic               io_req,
   input  logic  [ADDR_W-1:0] io_addr,
   input  logic               io_rd,
   input  logic               io_wr,
   input  logic    [XLEN-1:0] io_wr_data,

   input  logic               ext_irq,                // External interrupt
   input  logic               wfi,                    // Wait-for-interrupt pulse

   // I/O acknowledge
   output logic               io_ack,
   output logic               io_ack_fault,
   output logic    [XLEN-1:0] io_ack_data,

   output logic               timer_irq,
   output logic               sw_irq,
   output logic               cpu_halt
);

   mmr_wr_if                  wr_bus ();              // Decoder to datapaths

   time_word_t                mtime;
   time_word_t                mtimecmp;

   //--------------------------------------------------------------------------
   // Control, decode and halt
   //--------------------------------------------------------------------------
   clint_ctrl ctrl
   (
      .clk_in(clk_in), .rst(rst),

      .io_req(io_req),
      .io_addr(io_addr),
      .io_rd(io_rd),
      .io_wr(io_wr),
      .io_wr_data(io_wr_data),

      .ext_irq(ext_irq),
      .wfi(wfi),
      .timer_irq(timer_irq),                          // Also a wake source

      .mtime(mtime),                                  // Read-back
      .mtimecmp(mtimecmp),

      .wr(wr_bus),

      .io_ack(io_ack),
      .io_ack_fault(io_ack_fault),
      .io_ack_data(io_ack_data),

      .sw_irq(sw_irq),
      .cpu_halt(cpu_halt)
   );

   // Machine timer
   mtime_counter mtime_cnt
   (
      .clk_in(clk_in), .rst(rst),
      .wr(wr_bus),
      .mtime(mtime)
   );

   // Compare and timer interrupt
   timer_compare tcmp
   (
      .clk_in(clk_in), .rst(rst),
      .wr(wr_bus),
      .mtime(mtime),
      .mtimecmp(mtimecmp),
      .timer_irq(timer_irq)
   );

endmodule

/* logic/timer_compare.sv */
`timescale 1ns/1ps

module timer_compare
   import clint_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst,

   mmr_wr_if.cmp              wr,                     // Half-word loads
   input  time_word_t         mtime,                  // Current timer value

   output time_word_t         mtimecmp,
   output logic               timer_irq               // mtime has reached mtimecmp
);

   //--------------------------------------------------------------------------
   // Compare register
   //--------------------------------------------------------------------------
   // Reset to all ones so the interrupt stays quiet until software sets it
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtimecmp.count <= MTIMECMP_RESET;
      else if (wr.mtimecmp_lo_wr)
         mtimecmp.half.lo <= wr.wr_data;
      else if (wr.mtimecmp_hi_wr)
         mtimecmp.half.hi <= wr.wr_data;
   end

   //--------------------------------------------------------------------------
   // Timer interrupt
   //--------------------------------------------------------------------------
   // Unsigned 64-bit compare on the full views
   // Level signal, drops as soon as mtimecmp is moved ahead again
   assign timer_irq = (mtime.count >= mtimecmp.count);

endmodule

/* logic/mtime_counter.sv */
`timescale 1ns/1ps

module mtime_counter
   import clint_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst,

   mmr_wr_if.timer            wr,                     // Half-word loads

   output time_word_t         mtime                   // Free-running timer
);

   //--------------------------------------------------------------------------
   // Machine timer
   //--------------------------------------------------------------------------
   // Counts every clock
   // A load replaces one half and skips that cycle's increment
   // The other half keeps its value at that edge
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtime.count <= '0;
      else if (wr.mtime_lo_wr)
         mtime.half.lo <= wr.wr_data;                 // Upper word holds
      else if (wr.mtime_hi_wr)
         mtime.half.hi <= wr.wr_data;                 // Lower word holds
      else
         mtime.count <= mtime.count + 1'b1;           // Carry crosses the halves
   end

endmodule

/* logic/clint_ctrl.sv */
`timescale 1ns/1ps

module clint_ctrl
   import clint_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst,

   // I/O request, one-cycle strobe
   input  logic               io_req,
   input  logic  [ADDR_W-1:0] io_addr,
   input  logic               io_rd,
   input  logic               io_wr,
   input  logic    [XLEN-1:0] io_wr_data,

   // Wake sources and sleep request
   input  logic               ext_irq,
   input  logic               wfi,
   input  logic               timer_irq,

   // Current register contents for read-back
   input  time_word_t         mtime,
   input  time_word_t         mtimecmp,

   mmr_wr_if.ctrl             wr,                     // Write strobes to datapaths

   // Acknowledge, one cycle after the request
   output logic               io_ack,
   output logic               io_ack_fault,
   output logic    [XLEN-1:0] io_ack_data,

   output logic               sw_irq,
   output logic               cpu_halt
);

   logic                      valid_op;               // Exactly one of rd/wr
   logic                      addr_hit;               // Address is in the map
   logic                      req_ok;                 // Request will be served
   logic                      rd_ok;
   logic                      wr_ok;
   logic           [XLEN-1:0] rd_mux;                 // Addressed word
   logic           [XLEN-1:0] rd_data;                // Zero unless a legal read
   logic                      msip;                   // Software interrupt pending
   logic                      msip_wr;
   logic                      irq_pending;            // Any wake source

   //--------------------------------------------------------------------------
   // Address decode and read-back
   //--------------------------------------------------------------------------
   assign valid_op = io_rd ^ io_wr;                   // Neither or both is a fault

   always_comb
   begin
      addr_hit = 1'b1;
      rd_mux   = '0;
      case (io_addr)
         MSIP_ADDR:        rd_mux = {{(XLEN-1){1'b0}}, msip};
         MTIMECMP_LO_ADDR: rd_mux = mtimecmp.half.lo;
         MTIMECMP_HI_ADDR: rd_mux = mtimecmp.half.hi;
         MTIME_LO_ADDR:    rd_mux = mtime.half.lo;
         MTIME_HI_ADDR:    rd_mux = mtime.half.hi;
         default:          addr_hit = 1'b0;          // Unmapped
      endcase
   end

   assign req_ok  = io_req & valid_op & addr_hit;
   assign rd_ok   = req_ok & io_rd;
   assign wr_ok   = req_ok & io_wr;

   // Faulted or write requests return zero
   assign rd_data = rd_ok ? rd_mux : '0;

   //--------------------------------------------------------------------------
   // Write strobes
   //--------------------------------------------------------------------------
   // At most one strobe per request, taken at the same edge
   assign wr.mtime_lo_wr    = wr_ok & (io_addr == MTIME_LO_ADDR);
   assign wr.mtime_hi_wr    = wr_ok & (io_addr == MTIME_HI_ADDR);
   assign wr.mtimecmp_lo_wr = wr_ok & (io_addr == MTIMECMP_LO_ADDR);
   assign wr.mtimecmp_hi_wr = wr_ok & (io_addr == MTIMECMP_HI_ADDR);
   assign wr.wr_data        = io_wr_data;             // Shared by all halves

   assign msip_wr           = wr_ok & (io_addr == MSIP_ADDR);

   // Software interrupt bit
   always_ff @(posedge clk_in)
   begin
      if (rst)
         msip <= 1'b0;
      else if (msip_wr)
         msip <= io_wr_data[0];                       // Only bit 0 is implemented
   end

   assign sw_irq = msip;

   //--------------------------------------------------------------------------
   // Acknowledge
   //--------------------------------------------------------------------------
   // Every request gets exactly one ack on the next cycle, no back-pressure
   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         io_ack       <= 1'b0;
         io_ack_fault <= 1'b0;
      end
      else
      begin
         io_ack       <= io_req;
         io_ack_fault <= io_req & ~req_ok;            // Bad op or bad address
      end
   end

   // Value held before the request edge
   always_ff @(posedge clk_in)
   begin
      io_ack_data <= rd_data;
   end

   //--------------------------------------------------------------------------
   // Halt control
   //--------------------------------------------------------------------------
   assign irq_pending = ext_irq | timer_irq | sw_irq;

   // Sleep on wfi, wake on any interrupt
   always_ff @(posedge clk_in)
   begin
      if (rst)
         cpu_halt <= 1'b0;
      else if (irq_pending)
         cpu_halt <= 1'b0;                            // Wake has priority
      else if (wfi)
         cpu_halt <= 1'b1;                            // Nothing pending, go to sleep
   end

endmodule

/* logic/mmr_wr_if.sv */
`timescale 1ns/1ps

// Register write path from the decoder to the timer datapaths
interface mmr_wr_if
   import clint_pkg::*;
();

   logic             mtime_lo_wr;                     // Load mtime bits 31:0
   logic             mtime_hi_wr;                     // Load mtime bits 63:32
   logic             mtimecmp_lo_wr;                  // Load mtimecmp bits 31:0
   logic             mtimecmp_hi_wr;                  // Load mtimecmp bits 63:32
   logic  [XLEN-1:0] wr_data;                         // Shared write word

   // Decoder side
   modport ctrl
   (
      output mtime_lo_wr, mtime_hi_wr, mtimecmp_lo_wr, mtimecmp_hi_wr, wr_data
   );

   // mtime counter side
   modport timer
   (
      input  mtime_lo_wr, mtime_hi_wr, wr_data
   );

   // mtimecmp side
   modport cmp
   (
      input  mtimecmp_lo_wr, mtimecmp_hi_wr, wr_data
   );

endinterface

/* logic/clint_pkg.sv */
package clint_pkg;

   //--------------------------------------------------------------------------
   // Widths
   //--------------------------------------------------------------------------
   localparam int XLEN   = 32;                        // I/O data word
   localparam int ADDR_W = 32;                        // I/O byte address
   localparam int TIME_W = 64;                        // mtime and mtimecmp

   //--------------------------------------------------------------------------
   // Address map
   //--------------------------------------------------------------------------
   // All registers are word aligned, one word per address
   localparam logic [ADDR_W-1:0] MSIP_ADDR        = 32'h0200_0000; // Software irq bit

   localparam logic [ADDR_W-1:0] MTIMECMP_LO_ADDR = 32'h0200_4000; // Compare, bits 31:0
   localparam logic [ADDR_W-1:0] MTIMECMP_HI_ADDR = 32'h0200_4004; // Compare, bits 63:32

   localparam logic [ADDR_W-1:0] MTIME_LO_ADDR    = 32'h0200_BFF8; // Timer, bits 31:0
   localparam logic [ADDR_W-1:0] MTIME_HI_ADDR    = 32'h0200_BFFC; // Timer, bits 63:32

   //--------------------------------------------------------------------------
   // Reset values
   //--------------------------------------------------------------------------
   // Compare starts at the top of the range, so mtime cannot reach it early
   localparam logic [TIME_W-1:0] MTIMECMP_RESET   = {TIME_W{1'b1}};

   //--------------------------------------------------------------------------
   // Timer word
   //--------------------------------------------------------------------------
   // Same 64 bits seen two ways
   //   count : whole value, used for increment and compare
   //   half  : hi/lo words, used by the 32-bit I/O port
   typedef union packed
   {
      logic [TIME_W-1:0] count;                       // Full 64-bit view
      struct packed
      {
         logic [XLEN-1:0] hi;                         // Upper word
         logic [XLEN-1:0] lo;                         // Lower word
      } half;
   } time_word_t;

endpackage
